// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_load_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/line_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_defs.svh"

module line_fifo
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    we,
    input  load_pkg::line_t         wdata,

    input  logic                    re,
    output load_pkg::line_t         rdata,
    output logic                    rvalid,

    output logic                    empty,
    output logic [`LOG2_PREFETCH:0] count
);
    import load_pkg::*;

    line_t mem [`PREFETCH_DEPTH];

    logic [`LOG2_PREFETCH-1:0] wr_ptr;
    logic [`LOG2_PREFETCH-1:0] rd_ptr;
    logic do_write;
    logic do_read;

    assign empty    = (count == '0);
    assign do_write = we && (count != `PREFETCH_DEPTH); // drop when full
    assign do_read  = re && !empty;

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_read)
        begin
            rdata <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= do_read;
            if (do_write)
            begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/load_defs.svh ====
`ifndef LOAD_DEFS_SVH
`define LOAD_DEFS_SVH

// data path widths
`define LINE_BITS 512
`define ADDR_BITS 42

// prefetch FIFO sizing
`define LOG2_PREFETCH 5
`define PREFETCH_DEPTH (1 << `LOG2_PREFETCH)

// host register map
`define REG_BASE   2'd0
`define REG_OFFSET 2'd1
`define REG_LENGTH 2'd2

`endif

// ==== hdl/load_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_defs.svh"

module load_engine
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    start,
    output logic                    done,

    input  load_pkg::line_addr_t    base_addr,
    input  logic [31:0]             line_offset,
    input  logic [30:0]             line_count,
    input  logic                    multiline,

    input  logic                    req_almfull,
    output logic                    req_valid,
    output load_pkg::line_addr_t    req_addr,
    output load_pkg::burst_len_t    req_len,
    output logic [15:0]             req_tag,

    input  logic [`LOG2_PREFETCH:0] fifo_count,
    input  logic                    fifo_empty,
    input  logic                    fifo_rvalid,
    input  load_pkg::line_t         fifo_rdata,
    output logic                    fifo_re,
    output logic                    recv_active,

    input  logic                    out_almfull,
    output logic                    out_we,
    output load_pkg::line_t         out_data
);
    import load_pkg::*;

    // lines that may be requested before the credit pipeline catches up
    localparam int STALE_MARGIN = 12;

    load_state_t request_state;
    load_state_t receive_state;
    logic        go;

    line_addr_t  next_addr;
    logic [31:0] load_length;
    logic        multiline_en;

    logic [31:0]        requested_lines;
    logic [31:0]        received_lines;
    logic [31:0]        lines_in_flight;
    logic signed [31:0] fifo_free;
    logic signed [31:0] allowed_lines;

    logic       can_issue;
    logic       fits_four;
    logic       fits_two;
    burst_len_t burst;
    logic [2:0] burst_lines;

    assign go = start && (request_state == STATE_IDLE) && (receive_state == STATE_IDLE);
    assign recv_active = (receive_state == STATE_READ);

    assign can_issue = !req_almfull && (allowed_lines > 0) && (requested_lines < load_length);
    assign fits_four = multiline_en && (next_addr[1:0] == 2'b00) &&
                       (requested_lines + 32'd4 < load_length);
    assign fits_two  = multiline_en && (next_addr[0] == 1'b0) &&
                       (requested_lines + 32'd2 < load_length);

    always_comb
    begin
        if (fits_four)
        begin
            burst       = BURST_4;
            burst_lines = 3'd4;
        end
        else if (fits_two)
        begin
            burst       = BURST_2;
            burst_lines = 3'd2;
        end
        else
        begin
            burst       = BURST_1;
            burst_lines = 3'd1;
        end
    end

    // credit computed over two register stages
    always_ff @(posedge clk)
    begin
        lines_in_flight <= requested_lines - received_lines;
        fifo_free       <= $signed(32'(`PREFETCH_DEPTH)) - $signed(32'(fifo_count));
        if (reset || (request_state != STATE_READ))
        begin
            allowed_lines <= '0;
        end
        else
        begin
            allowed_lines <= fifo_free - $signed(lines_in_flight) - STALE_MARGIN;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            request_state   <= STATE_IDLE;
            requested_lines <= '0;
            req_valid       <= 1'b0;
        end
        else
        begin
            req_valid <= 1'b0;
            case (request_state)
                STATE_IDLE:
                begin
                    if (go)
                    begin
                        next_addr       <= base_addr + line_addr_t'(line_offset);
                        load_length     <= {1'b0, line_count};
                        multiline_en    <= multiline;
                        requested_lines <= '0;
                        request_state   <= (line_count == '0) ? STATE_DONE : STATE_READ;
                    end
                end

                STATE_READ:
                begin
                    if (can_issue)
                    begin
                        req_valid       <= 1'b1;
                        req_addr        <= next_addr;
                        req_len         <= burst;
                        req_tag         <= requested_lines[15:0];
                        requested_lines <= requested_lines + 32'(burst_lines);
                        next_addr       <= next_addr + line_addr_t'(burst_lines);
                    end
                    if (requested_lines == load_length)
                    begin
                        request_state <= STATE_DONE;
                    end
                end

                default:
                begin
                    request_state <= STATE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            receive_state  <= STATE_IDLE;
            received_lines <= '0;
            fifo_re        <= 1'b0;
            out_we         <= 1'b0;
            done           <= 1'b0;
        end
        else
        begin
            fifo_re <= !fifo_empty && !out_almfull;
            out_we  <= 1'b0;
            done    <= 1'b0;
            case (receive_state)
                STATE_IDLE:
                begin
                    if (go)
                    begin
                        received_lines <= '0;
                        receive_state  <= (line_count == '0) ? STATE_DONE : STATE_READ;
                    end
                end

                STATE_READ:
                begin
                    if (fifo_rvalid)
                    begin
                        out_we         <= 1'b1;
                        out_data       <= fifo_rdata;
                        received_lines <= received_lines + 1'b1;
                        if (received_lines == load_length - 1'b1)
                        begin
                            receive_state <= STATE_DONE; // last line out
                        end
                    end
                end

                default:
                begin
                    done          <= 1'b1;
                    receive_state <= STATE_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/load_pkg.sv ====
`default_nettype none

`include "load_defs.svh"

package load_pkg;

    typedef logic [`LINE_BITS-1:0] line_t;      // one cache line
    typedef logic [`ADDR_BITS-1:0] line_addr_t; // cache-line granular

    // encoding follows the memory request header
    typedef enum logic [1:0]
    {
        BURST_1 = 2'b00,
        BURST_2 = 2'b01,
        BURST_4 = 2'b11
    } burst_len_t;

    typedef enum logic [1:0]
    {
        STATE_IDLE,
        STATE_READ,
        STATE_DONE
    } load_state_t;

endpackage

`default_nettype wire

// ==== hdl/load_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_defs.svh"

module load_regs
(
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 reg_we,
    input  logic [1:0]           reg_addr,
    input  logic [63:0]          reg_wdata,
    output logic [63:0]          reg_rdata,

    output load_pkg::line_addr_t base_addr,
    output logic [31:0]          line_offset,
    output logic [30:0]          line_count,
    output logic                 multiline
);

    logic [63:0] base_reg;
    logic [31:0] offset_reg;
    logic [31:0] length_reg; // count plus multi-line enable

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            base_reg   <= '0;
            offset_reg <= '0;
            length_reg <= '0;
        end
        else if (reg_we)
        begin
            case (reg_addr)
                `REG_BASE:   base_reg   <= reg_wdata;
                `REG_OFFSET: offset_reg <= reg_wdata[31:0];
                `REG_LENGTH: length_reg <= reg_wdata[31:0];
                default:     ; // unmapped
            endcase
        end
    end

    always_comb
    begin
        case (reg_addr)
            `REG_BASE:   reg_rdata = base_reg;
            `REG_OFFSET: reg_rdata = {32'b0, offset_reg};
            `REG_LENGTH: reg_rdata = {32'b0, length_reg};
            default:     reg_rdata = '0;
        endcase
    end

    assign base_addr   = base_reg[`ADDR_BITS-1:0];
    assign line_offset = offset_reg;
    assign line_count  = length_reg[30:0];
    assign multiline   = length_reg[31];

endmodule

`default_nettype wire

// ==== hdl/load_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_defs.svh"

module load_top
(
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 reg_we,
    input  logic [1:0]           reg_addr,
    input  logic [63:0]          reg_wdata,
    output logic [63:0]          reg_rdata,

    input  logic                 start,
    output logic                 done,

    output logic                 req_valid,
    output load_pkg::line_addr_t req_addr,
    output load_pkg::burst_len_t req_len,
    output logic [15:0]          req_tag,
    input  logic                 req_almfull,

    input  logic                 rsp_valid,
    input  load_pkg::line_t      rsp_data,

    output logic                 out_we,
    output load_pkg::line_t      out_data,
    input  logic                 out_almfull
);
    import load_pkg::*;

    line_addr_t  base_addr;
    logic [31:0] line_offset;
    logic [30:0] line_count;
    logic        multiline;

    logic                    fifo_we;
    logic                    fifo_re;
    line_t                   fifo_rdata;
    logic                    fifo_rvalid;
    logic                    fifo_empty;
    logic [`LOG2_PREFETCH:0] fifo_count;
    logic                    recv_active;

    assign fifo_we = rsp_valid && recv_active; // stray responses dropped

    load_regs i_load_regs
    (
        .clk,
        .reset,
        .reg_we,
        .reg_addr,
        .reg_wdata,
        .reg_rdata,
        .base_addr,
        .line_offset,
        .line_count,
        .multiline
    );

    load_engine i_load_engine
    (
        .clk,
        .reset,
        .start,
        .done,
        .base_addr,
        .line_offset,
        .line_count,
        .multiline,
        .req_almfull,
        .req_valid,
        .req_addr,
        .req_len,
        .req_tag,
        .fifo_count,
        .fifo_empty,
        .fifo_rvalid,
        .fifo_rdata,
        .fifo_re,
        .recv_active,
        .out_almfull,
        .out_we,
        .out_data
    );

    line_fifo i_line_fifo
    (
        .clk,
        .reset,
        .we     (fifo_we),
        .wdata  (rsp_data),
        .re     (fifo_re),
        .rdata  (fifo_rdata),
        .rvalid (fifo_rvalid),
        .empty  (fifo_empty),
        .count  (fifo_count)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/load_pkg.sv
hdl/line_fifo.sv
hdl/load_regs.sv
hdl/load_engine.sv
hdl/load_top.sv
tb/mem_responder.sv
tb/tb_load_top.sv

// ==== tb/mem_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_defs.svh"

module mem_responder
#(
    parameter int SEED = 1
)
(
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 req_valid,
    input  load_pkg::line_addr_t req_addr,
    input  load_pkg::burst_len_t req_len,
    output logic                 req_almfull,

    output logic                 rsp_valid,
    output load_pkg::line_t      rsp_data
);
    import load_pkg::*;

    line_addr_t pending [$]; // line addresses in request order
    int         seed = SEED;
    int         wait_cycles;

    function automatic int lines_in_burst(input burst_len_t len);
        case (len)
            BURST_4: return 4;
            BURST_2: return 2;
            default: return 1;
        endcase
    endfunction

    // every 64-bit word carries its index and the full line address
    function automatic line_t fill_line(input line_addr_t a);
        line_t l;
        int    k;
        for (k = 0; k < `LINE_BITS / 64; k++)
        begin
            l[k*64 +: 64] = {8'(k), 14'h2a5, a};
        end
        return l;
    endfunction

    initial
    begin
        req_almfull = 1'b0;
        rsp_valid   = 1'b0;
        rsp_data    = '0;
        wait_cycles = 0;
    end

    always @(posedge clk)
    begin
        int i;
        if (reset)
        begin
            pending.delete();
        end
        else if (req_valid)
        begin
            for (i = 0; i < lines_in_burst(req_len); i++)
            begin
                pending.push_back(req_addr + line_addr_t'(i));
            end
        end
    end

    always @(negedge clk)
    begin
        if (reset)
        begin
            req_almfull = 1'b0;
            rsp_valid   = 1'b0;
            wait_cycles = 0;
        end
        else
        begin
            if (($random(seed) & 15) == 0)
            begin
                req_almfull = !req_almfull; // occasional back-pressure
            end
            rsp_valid = 1'b0;
            if (wait_cycles > 0)
            begin
                wait_cycles--;
            end
            else if (pending.size() > 0)
            begin
                rsp_valid   = 1'b1;
                rsp_data    = fill_line(pending.pop_front());
                wait_cycles = (($random(seed) & 7) == 0) ? 6 : ($random(seed) & 1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_load_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "load_defs.svh"

module tb_load_top;
    import load_pkg::*;

    localparam int RAND_SEED       = 28642;
    localparam int TOTAL_LINES     = 148; // upper bound over all runs below
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_LINES + 2000;

    logic        clk;
    logic        reset;
    logic        reg_we;
    logic [1:0]  reg_addr;
    logic [63:0] reg_wdata;
    logic [63:0] reg_rdata;
    logic        start;
    logic        done;
    logic        req_valid;
    line_addr_t  req_addr;
    burst_len_t  req_len;
    logic [15:0] req_tag;
    logic        req_almfull;
    logic        rsp_valid;
    line_t       rsp_data;
    logic        out_we;
    line_t       out_data;
    logic        out_almfull;

    int          seed = RAND_SEED;
    int          stall_seed = RAND_SEED;
    int          stall_left;
    int          errors;
    int          runs;
    logic [63:0] shadow [4]; // expected register contents
    logic        read_check;
    logic        stall_run;
    logic [63:0] rnd_base;
    logic [31:0] rnd_offset;
    logic [30:0] rnd_count;

    logic        running;
    line_addr_t  first_addr;
    line_addr_t  expect_addr;
    logic [31:0] run_length;
    logic        run_multi;
    logic [31:0] req_lines;
    logic [31:0] out_lines;
    logic [31:0] since_start;
    logic [31:0] stall_we;
    logic        prev_out_we;
    logic        prev_almfull;
    logic        prev_reset = 1'b0;
    burst_len_t  expect_len;
    logic [2:0]  len_lines;

    load_top i_load_top (.*);

    mem_responder #(.SEED(RAND_SEED)) i_mem_responder
    (
        .clk,
        .reset,
        .req_valid,
        .req_addr,
        .req_len,
        .req_almfull,
        .rsp_valid,
        .rsp_data
    );

    always #5 clk = ~clk;

    function automatic line_t line_pattern(input line_addr_t a);
        line_t p;
        int    k;
        for (k = 0; k < `LINE_BITS / 64; k++)
        begin
            p[k*64 +: 64] = {8'(k), 14'h2a5, a};
        end
        return p;
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        errors++;
    endtask

    always_comb
    begin
        case (req_len)
            BURST_4: len_lines = 3'd4;
            BURST_2: len_lines = 3'd2;
            default: len_lines = 3'd1;
        endcase
    end

    // burst choice from alignment and lines left
    always_comb
    begin
        if (run_multi && expect_addr[1:0] == 2'b00 && req_lines + 32'd4 < run_length)
            expect_len = BURST_4;
        else if (run_multi && !expect_addr[0] && req_lines + 32'd2 < run_length)
            expect_len = BURST_2;
        else
            expect_len = BURST_1;
    end

    always @(posedge clk)
    begin
        prev_reset   <= reset;
        prev_out_we  <= out_we;
        prev_almfull <= out_almfull;
        if (reset)
        begin
            running     <= 1'b0;
            first_addr  <= '0;
            expect_addr <= '0;
            run_length  <= '0;
            run_multi   <= 1'b0;
            req_lines   <= '0;
            out_lines   <= '0;
            since_start <= '0;
            stall_we    <= '0;
        end
        else
        begin
            since_start <= since_start + 1;
            if (start)
            begin
                running     <= 1'b1;
                first_addr  <= shadow[`REG_BASE][`ADDR_BITS-1:0] +
                               line_addr_t'(shadow[`REG_OFFSET][31:0]);
                expect_addr <= shadow[`REG_BASE][`ADDR_BITS-1:0] +
                               line_addr_t'(shadow[`REG_OFFSET][31:0]);
                run_length  <= {1'b0, shadow[`REG_LENGTH][30:0]};
                run_multi   <= shadow[`REG_LENGTH][31];
                req_lines   <= '0;
                out_lines   <= '0;
                since_start <= 32'd1;
            end
            if (req_valid)
            begin
                req_lines   <= req_lines + len_lines;
                expect_addr <= expect_addr + len_lines;
            end
            if (out_we)
                out_lines <= out_lines + 1;
            if (done)
                running <= 1'b0;
            if (out_almfull && prev_almfull)
                stall_we <= stall_we + out_we; // lines seen during a held stall
            else
                stall_we <= '0;
        end
    end

    // long random stretches of downstream back-pressure
    always @(negedge clk)
    begin
        if (!(running && stall_run))
        begin
            out_almfull = 1'b0;
            stall_left  = 0;
        end
        else if (stall_left > 0)
        begin
            stall_left--;
        end
        else
        begin
            out_almfull = !out_almfull;
            stall_left  = out_almfull ? 20 + ($random(stall_seed) & 63)
                                      : ($random(stall_seed) & 15);
        end
    end

    reset_state: assert property (@(posedge clk) prev_reset |-> !req_valid && !out_we && !done)
        else flag_mismatch("outputs active right after reset");

    data_order: assert property (@(posedge clk) disable iff (reset)
        out_we |-> out_data == line_pattern(first_addr + out_lines))
        else flag_mismatch("out_data differs from expected line pattern");

    out_in_run: assert property (@(posedge clk) disable iff (reset)
        out_we |-> running && out_lines < run_length)
        else flag_mismatch("out_we beyond the line count");

    done_count: assert property (@(posedge clk) disable iff (reset)
        done |-> running && out_lines == run_length && req_lines == run_length)
        else flag_mismatch("done with wrong requested or written line count");

    done_timing: assert property (@(posedge clk) disable iff (reset)
        done |-> (run_length == 0 && since_start == 2) || (run_length != 0 && prev_out_we))
        else flag_mismatch("done not one cycle after last line");

    burst_rule: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> running && req_len == expect_len && req_lines + len_lines <= run_length)
        else flag_mismatch("request length breaks burst rule");

    request_addr: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> req_addr == expect_addr && req_tag == req_lines[15:0])
        else flag_mismatch("request address or tag out of sequence");

    almfull_gate: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> !$past(req_almfull))
        else flag_mismatch("request issued while req_almfull was high");

    credit_limit: assert property (@(posedge clk) disable iff (reset)
        req_lines <= out_lines + `PREFETCH_DEPTH + 2)
        else flag_mismatch("lines in flight exceed prefetch depth plus drain");

    stall_drain: assert property (@(posedge clk) disable iff (reset)
        out_almfull && prev_almfull && out_we |-> stall_we < 2)
        else flag_mismatch("more than two lines after out_almfull rose");

    reg_readback: assert property (@(posedge clk) disable iff (reset)
        read_check |-> reg_rdata == shadow[reg_addr])
        else flag_mismatch("register readback differs from written value");

    task automatic write_reg(input logic [1:0] addr, input logic [63:0] data);
        @(negedge clk);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        case (addr)
            `REG_BASE:   shadow[addr] = data;
            `REG_OFFSET: shadow[addr] = {32'b0, data[31:0]};
            `REG_LENGTH: shadow[addr] = {32'b0, data[31:0]};
            default:     ; // unmapped address reads zero
        endcase
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    task automatic check_regs();
        int a;
        for (a = 0; a < 4; a++)
        begin
            @(negedge clk);
            reg_addr   = 2'(a);
            read_check = 1'b1;
        end
        @(negedge clk);
        read_check = 1'b0;
    endtask

    task automatic run_load(input logic [63:0] base, input logic [31:0] offset,
                            input logic [30:0] count, input logic multi, input logic stall);
        stall_run = stall;
        write_reg(`REG_BASE, base);
        write_reg(`REG_OFFSET, {32'($random(seed)), offset}); // upper half ignored
        write_reg(`REG_LENGTH, {32'($random(seed)), multi, count});
        check_regs();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        do
        begin
            @(negedge clk);
        end
        while (!done);
        repeat (4) @(negedge clk);
        stall_run = 1'b0;
        runs++;
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        reg_we      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        start       = 1'b0;
        out_almfull = 1'b0;
        read_check  = 1'b0;
        stall_run   = 1'b0;
        errors      = 0;
        runs        = 0;
        for (int i = 0; i < 4; i++)
            shadow[i] = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_regs();

        run_load(64'hdead_beef_0000_1000, 32'd3, 31'd10, 1'b0, 1'b0);
        run_load(64'h0000_0123_4567_8a45, 32'd1, 31'd37, 1'b1, 1'b0);
        run_load(64'h0000_0000_0000_2000, 32'd7, 31'd0, 1'b1, 1'b0);
        run_load(64'h0000_03ff_ffff_fff0, 32'd14, 31'd64, 1'b1, 1'b1); // wraps 42 bits
        run_load(64'h0000_0000_0000_0040, 32'd0, 31'd5, 1'b1, 1'b0);
        rnd_base   = {$random(seed), $random(seed)};
        rnd_offset = $random(seed) & 32'hff;
        rnd_count  = 31'(1 + ($random(seed) & 31));
        run_load(rnd_base, rnd_offset, rnd_count, rnd_base[7], 1'b1);

        $display("runs: %0d  errors: %0d", runs, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: loads not finished after %0d cycles, runs: %0d  errors: %0d",
                 WATCHDOG_CYCLES, runs, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
